//--- back_end.f
common/trap_pkg.sv
common/core_pkg.sv
execution/execution_unit.sv
hdl/commit_stage.sv
reorder_buffer/reorder_buffer.sv
hdl/writeback_stage.sv
hdl/trap_manager.sv
hdl/back_end.sv
bench/back_end_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = back_end_tb
FILE_LIST  = back_end.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
PASS_TEXT  = SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/back_end_tb.sv
`default_nettype none

module back_end_tb
    import core_pkg::*;
    import trap_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 56248;
    localparam int ALU_COUNT    = 40;
    localparam int MIX_COUNT    = 24;                   // Groups of one multiply and three ALU ops
    localparam int ZERO_COUNT   = 16;
    localparam int RESUME_COUNT = 20;
    // About four cycles per instruction, plus reset and the trap sequence
    localparam int TEST_CYCLES  = RESET_CYCLES + 90
                                + 4 * (ALU_COUNT + MIX_COUNT + ZERO_COUNT + RESUME_COUNT);
    localparam int WATCHDOG_NS  = 4 * CLK_PERIOD * TEST_CYCLES;

    logic          clk_i = 1'b0;
    logic          rst_n_i;
    logic          issue_valid_i;
    data_word_t    operand_1_i;
    data_word_t    operand_2_i;
    instr_packet_t ipacket_i;
    logic          machine_return_i;
    rob_tag_t      rob_read_ptr_o;
    logic          writeback_o;
    reg_addr_t     reg_destination_o;
    data_word_t    writeback_result_o;
    logic          clear_pipeline_o;
    logic          set_handler_pc_o;
    logic          block_front_end_o;
    logic          resume_execution_pc_o;
    data_word_t    handler_pc_o;
    data_word_t    mepc_o;

    reg_addr_t     exp_dest_q [$];                      // Expected writes in program order
    data_word_t    exp_result_q [$];
    reg_addr_t     popped_dest;
    data_word_t    popped_result;
    rob_tag_t      next_tag;
    data_word_t    next_pc;
    data_word_t    fault_pc;
    string         test_name;
    int            value_errors;
    int            other_errors;

    back_end back_end_inst (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

//==================================================
//  Reference model and reporting
//==================================================

    function automatic data_word_t expected_result(input exu_op_t op, input data_word_t a,
                                                   input data_word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;                      // Low word only
            default: return '0;
        endcase
    endfunction

    task automatic log_mismatch(input string what, input data_word_t exp, input data_word_t act);
        value_errors++;
        $display("ERR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    endtask

    task automatic note_failure(input string msg);
        other_errors++;
        $display("Failure in %s: %s", test_name, msg);
    endtask

//==================================================
//  Front end
//==================================================

    task automatic idle_cycle();
        issue_valid_i = 1'b0;
        @(posedge clk_i);
        #1;
    endtask

    task automatic issue_instr(input exu_op_t op, input reg_addr_t dest, input logic track);
        data_word_t a;
        data_word_t b;
        a = $urandom();
        b = $urandom();
        // Seven in flight at most, and nothing while parked in the handler
        while (block_front_end_o
               || (rob_tag_t'(next_tag - rob_read_ptr_o) == rob_tag_t'(ROB_DEPTH - 1))) begin
            idle_cycle();
        end
        issue_valid_i = 1'b1;
        operand_1_i   = a;
        operand_2_i   = b;
        ipacket_i     = '{pc: next_pc, dest: dest, tag: next_tag, opcode: op};
        if (track && (dest != '0) && (op != OP_ILLEGAL)) begin
            exp_dest_q.push_back(dest);
            exp_result_q.push_back(expected_result(op, a, b));
        end
        next_tag = next_tag + 1'b1;
        next_pc  = next_pc + 32'd4;
        @(posedge clk_i);
        #1;
        issue_valid_i = 1'b0;
    endtask

    task automatic drain_pipeline(input int limit);
        int cycles;
        cycles = 0;
        while ((exp_dest_q.size() != 0 || rob_read_ptr_o != next_tag) && cycles < limit) begin
            idle_cycle();
            cycles++;
        end
        if (exp_dest_q.size() != 0 || rob_read_ptr_o != next_tag) begin
            note_failure($sformatf("%0d writes still missing after %0d cycles",
                                   exp_dest_q.size(), limit));
        end
    endtask

//==================================================
//  Checks
//==================================================

    always @(negedge clk_i) begin : writeback_monitor
        if (rst_n_i && writeback_o) begin
            if (exp_dest_q.size() == 0) begin
                note_failure($sformatf("register write to x%0d that no instruction owns",
                                       reg_destination_o));
            end else begin
                popped_dest   = exp_dest_q.pop_front();
                popped_result = exp_result_q.pop_front();
                assert (reg_destination_o == popped_dest)
                    else log_mismatch("destination", 32'(popped_dest), 32'(reg_destination_o));
                assert (writeback_result_o == popped_result)
                    else log_mismatch("result", popped_result, writeback_result_o);
            end
        end
    end

    no_zero_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        writeback_o |-> (reg_destination_o != '0))
        else note_failure("a write to register 0 reached the register file");

    clear_with_redirect : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        clear_pipeline_o == set_handler_pc_o)
        else note_failure("clear and redirect pulses are not aligned");

    clear_one_cycle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        clear_pipeline_o |=> !clear_pipeline_o)
        else note_failure("pipeline clear lasted more than one cycle");

    block_rises_with_clear : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(clear_pipeline_o) |-> $rose(block_front_end_o))
        else note_failure("front end block did not rise with the clear");

    block_holds : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (block_front_end_o && !machine_return_i) |=> block_front_end_o)
        else note_failure("front end block dropped without a machine return");

    return_releases : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (block_front_end_o && machine_return_i && !clear_pipeline_o)
            |=> (!block_front_end_o && resume_execution_pc_o))
        else note_failure("machine return did not release the front end");

    resume_one_cycle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resume_execution_pc_o |=> !resume_execution_pc_o)
        else note_failure("resume pulse lasted more than one cycle");

//==================================================
//  Test sequence
//==================================================

    initial begin : stimulus
        int cycles;
        void'($urandom(SEED));
        rst_n_i          = 1'b0;
        issue_valid_i    = 1'b0;
        operand_1_i      = '0;
        operand_2_i      = '0;
        ipacket_i        = '0;
        machine_return_i = 1'b0;
        next_tag         = '0;
        next_pc          = 32'h0000_1000;
        fault_pc         = '0;
        value_errors     = 0;
        other_errors     = 0;
        test_name        = "reset";
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        idle_cycle();
        assert ({writeback_o, clear_pipeline_o, set_handler_pc_o, resume_execution_pc_o,
                 block_front_end_o} == 5'b0)
            else log_mismatch("control outputs", '0, 32'({writeback_o, clear_pipeline_o,
                              set_handler_pc_o, resume_execution_pc_o, block_front_end_o}));
        assert (rob_read_ptr_o == '0)
            else log_mismatch("read pointer", '0, 32'(rob_read_ptr_o));

        test_name = "alu_order";
        repeat (ALU_COUNT) begin
            issue_instr(exu_op_t'($urandom_range(4, 0)), reg_addr_t'($urandom_range(31, 1)), 1'b1);
        end
        drain_pipeline(64);

        test_name = "mul_order";
        repeat (MIX_COUNT / 4) begin
            issue_instr(OP_MUL, reg_addr_t'($urandom_range(31, 1)), 1'b1);
            repeat (3) begin
                issue_instr(exu_op_t'($urandom_range(4, 0)),
                            reg_addr_t'($urandom_range(31, 1)), 1'b1);
            end
        end
        drain_pipeline(64);

        test_name = "zero_dest";
        repeat (ZERO_COUNT) begin
            issue_instr(exu_op_t'($urandom_range(5, 0)), reg_addr_t'($urandom_range(3, 0)), 1'b1);
        end
        drain_pipeline(64);

        test_name = "illegal_trap";
        fault_pc  = next_pc;
        issue_instr(OP_ILLEGAL, 5'd9, 1'b1);
        repeat (2) begin                                // Younger ops that the flush squashes
            issue_instr(exu_op_t'($urandom_range(4, 0)), reg_addr_t'($urandom_range(31, 1)), 1'b0);
        end
        cycles = 0;
        while (!clear_pipeline_o && cycles < 20) begin
            idle_cycle();
            cycles++;
        end
        if (!clear_pipeline_o) begin
            note_failure("no pipeline clear followed the illegal instruction");
        end else begin
            // Illegal instruction is cause 2 and each cause owns one word
            assert (handler_pc_o == HANDLER_BASE + 32'd8)
                else log_mismatch("handler pc", HANDLER_BASE + 32'd8, handler_pc_o);
            assert (mepc_o == fault_pc)
                else log_mismatch("mepc", fault_pc, mepc_o);
        end
        next_tag = '0;                                  // Tags restart after a flush
        repeat (6) idle_cycle();
        drain_pipeline(16);

        test_name = "resume";
        assert (block_front_end_o)
            else note_failure("front end not blocked while in the handler");
        machine_return_i = 1'b1;
        idle_cycle();
        machine_return_i = 1'b0;
        assert (resume_execution_pc_o && !block_front_end_o)
            else note_failure("no resume pulse after the machine return");
        repeat (RESUME_COUNT) begin
            issue_instr(exu_op_t'($urandom_range(5, 0)), reg_addr_t'($urandom_range(31, 1)), 1'b1);
        end
        drain_pipeline(64);
        repeat (4) idle_cycle();

        $display("Error counts: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule : back_end_tb

`default_nettype wire

//--- hdl/back_end.sv
`default_nettype none

module back_end
    import core_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          issue_valid_i,
    input  data_word_t    operand_1_i,
    input  data_word_t    operand_2_i,
    input  instr_packet_t ipacket_i,
    input  logic          machine_return_i,
    output rob_tag_t      rob_read_ptr_o,
    output logic          writeback_o,
    output reg_addr_t     reg_destination_o,
    output data_word_t    writeback_result_o,
    output logic          clear_pipeline_o,
    output logic          set_handler_pc_o,
    output logic          block_front_end_o,
    output logic          resume_execution_pc_o,
    output data_word_t    handler_pc_o,
    output data_word_t    mepc_o
);

    logic                  flush;
    exu_result_t           alu_result, mul_result;
    rob_entry_t            alu_entry, mul_entry;
    rob_tag_t              alu_tag, mul_tag;
    logic                  head_valid, retire;
    rob_entry_t            head_entry;
    logic                  exception;
    trap_pkg::trap_cause_t cause;
    data_word_t            exception_pc;

//==================================================
//  Execute and commit
//==================================================

    execution_unit execution_inst (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .flush_i       ( flush         ),
        .issue_valid_i ( issue_valid_i ),
        .operand_1_i   ( operand_1_i   ),
        .operand_2_i   ( operand_2_i   ),
        .ipacket_i     ( ipacket_i     ),
        .alu_result_o  ( alu_result    ),
        .mul_result_o  ( mul_result    )
    );

    commit_stage commit_inst (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .flush_i      ( flush      ),
        .alu_result_i ( alu_result ),
        .mul_result_i ( mul_result ),
        .alu_entry_o  ( alu_entry  ),
        .alu_tag_o    ( alu_tag    ),
        .mul_entry_o  ( mul_entry  ),
        .mul_tag_o    ( mul_tag    )
    );

//==================================================
//  Reorder, retire and trap
//==================================================

    reorder_buffer rob_inst (
        .clk_i        ( clk_i          ),
        .rst_n_i      ( rst_n_i        ),
        .flush_i      ( flush          ),
        .alu_entry_i  ( alu_entry      ),
        .alu_tag_i    ( alu_tag        ),
        .mul_entry_i  ( mul_entry      ),
        .mul_tag_i    ( mul_tag        ),
        .retire_i     ( retire         ),
        .head_valid_o ( head_valid     ),
        .head_entry_o ( head_entry     ),
        .read_ptr_o   ( rob_read_ptr_o )
    );

    writeback_stage writeback_inst (
        .head_valid_i   ( head_valid         ),
        .head_entry_i   ( head_entry         ),
        .retire_o       ( retire             ),
        .write_o        ( writeback_o        ),
        .reg_dest_o     ( reg_destination_o  ),
        .result_o       ( writeback_result_o ),
        .exception_o    ( exception          ),
        .cause_o        ( cause              ),
        .exception_pc_o ( exception_pc       )
    );

    trap_manager trap_inst (
        .clk_i                 ( clk_i                 ),
        .rst_n_i               ( rst_n_i               ),
        .exception_i           ( exception             ),
        .cause_i               ( cause                 ),
        .exception_pc_i        ( exception_pc          ),
        .machine_return_i      ( machine_return_i      ),
        .clear_pipeline_o      ( flush                 ),
        .set_handler_pc_o      ( set_handler_pc_o      ),
        .block_front_end_o     ( block_front_end_o     ),
        .resume_execution_pc_o ( resume_execution_pc_o ),
        .handler_pc_o          ( handler_pc_o          ),
        .mepc_o                ( mepc_o                )
    );

    assign clear_pipeline_o = flush;                    // Same strobe kills the datapath

endmodule : back_end

`default_nettype wire

//--- hdl/trap_manager.sv
`default_nettype none

module trap_manager
    import core_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        exception_i,
    input  trap_cause_t cause_i,
    input  data_word_t  exception_pc_i,
    input  logic        machine_return_i,
    output logic        clear_pipeline_o,
    output logic        set_handler_pc_o,
    output logic        block_front_end_o,
    output logic        resume_execution_pc_o,
    output data_word_t  handler_pc_o,
    output data_word_t  mepc_o
);

    trap_state_t state_q, state_d;
    logic        resume_q;
    data_word_t  handler_pc_q, mepc_q;

    always_comb begin : next_state
        state_d = state_q;
        case (state_q)
            TRAP_IDLE: begin
                if (exception_i) begin
                    state_d = TRAP_FLUSH;
                end
            end
            TRAP_FLUSH: state_d = TRAP_HANDLER;         // Single cycle
            TRAP_HANDLER: begin
                if (machine_return_i) begin
                    state_d = TRAP_IDLE;
                end
            end
            default: state_d = TRAP_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin : state_register
        if (!rst_n_i) begin
            state_q  <= TRAP_IDLE;
            resume_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            resume_q <= (state_q == TRAP_HANDLER) && machine_return_i;
        end
    end

    always_ff @(posedge clk_i) begin : trap_capture
        if ((state_q == TRAP_IDLE) && exception_i) begin
            mepc_q       <= exception_pc_i;
            handler_pc_q <= HANDLER_BASE + (32'(cause_i) << 2);  // Vectored entry
        end
    end

    assign clear_pipeline_o      = (state_q == TRAP_FLUSH);
    assign set_handler_pc_o      = (state_q == TRAP_FLUSH);
    assign block_front_end_o     = (state_q != TRAP_IDLE);
    assign resume_execution_pc_o = resume_q;
    assign handler_pc_o          = handler_pc_q;
    assign mepc_o                = mepc_q;

    clear_single_cycle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        clear_pipeline_o |=> !clear_pipeline_o);

endmodule : trap_manager

`default_nettype wire

//--- hdl/writeback_stage.sv
`default_nettype none

module writeback_stage
    import core_pkg::*;
    import trap_pkg::*;
(
    input  logic        head_valid_i,
    input  rob_entry_t  head_entry_i,
    output logic        retire_o,
    output logic        write_o,
    output reg_addr_t   reg_dest_o,
    output data_word_t  result_o,
    output logic        exception_o,
    output trap_cause_t cause_o,
    output data_word_t  exception_pc_o
);

    assign retire_o = head_valid_i;                     // One entry per cycle at most

    // x0 is hardwired, so its writes vanish here
    assign write_o     = head_valid_i && !head_entry_i.exception && (head_entry_i.dest != '0);
    assign exception_o = head_valid_i && head_entry_i.exception;

    assign reg_dest_o     = head_entry_i.dest;
    assign result_o       = head_entry_i.result;
    assign cause_o        = head_entry_i.cause;
    assign exception_pc_o = head_entry_i.pc;

endmodule : writeback_stage

`default_nettype wire

//--- reorder_buffer/reorder_buffer.sv
`default_nettype none

module reorder_buffer
    import core_pkg::*;
    import trap_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  rob_entry_t alu_entry_i,
    input  rob_tag_t   alu_tag_i,
    input  rob_entry_t mul_entry_i,
    input  rob_tag_t   mul_tag_i,
    input  logic       retire_i,
    output logic       head_valid_o,
    output rob_entry_t head_entry_o,
    output rob_tag_t   read_ptr_o
);

    rob_entry_t           entries_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] valid_q;
    rob_tag_t             read_ptr_q;
    logic                 alu_hit, mul_hit;

//==================================================
//  Storage
//==================================================

    always_ff @(posedge clk_i) begin : entry_write
        if (alu_entry_i.valid) begin
            entries_q[alu_tag_i] <= alu_entry_i;        // Slot chosen by tag, any order
        end
        if (mul_entry_i.valid) begin
            entries_q[mul_tag_i] <= mul_entry_i;
        end
    end

    always_ff @(posedge clk_i) begin : valid_bits
        if (!rst_n_i || flush_i) begin
            valid_q <= '0;
        end else begin
            if (alu_entry_i.valid) begin
                valid_q[alu_tag_i] <= 1'b1;
            end
            if (mul_entry_i.valid) begin
                valid_q[mul_tag_i] <= 1'b1;
            end
            if (retire_i) begin
                valid_q[read_ptr_q] <= 1'b0;            // Also covers a bypassed write
            end
        end
    end

    always_ff @(posedge clk_i) begin : read_pointer
        if (!rst_n_i || flush_i) begin
            read_ptr_q <= '0;
        end else if (retire_i) begin
            read_ptr_q <= read_ptr_q + 1'b1;
        end
    end

//==================================================
//  Head presentation
//==================================================

    // A write aimed at the head retires in its own cycle
    assign alu_hit = alu_entry_i.valid && (alu_tag_i == read_ptr_q);
    assign mul_hit = mul_entry_i.valid && (mul_tag_i == read_ptr_q);

    assign head_valid_o = !flush_i && (valid_q[read_ptr_q] || alu_hit || mul_hit);

    always_comb begin : head_select
        head_entry_o       = '0;
        head_entry_o.cause = CAUSE_NONE;
        if (valid_q[read_ptr_q]) begin
            head_entry_o = entries_q[read_ptr_q];
        end else if (alu_hit) begin
            head_entry_o = alu_entry_i;
        end else if (mul_hit) begin
            head_entry_o = mul_entry_i;
        end
        head_entry_o.valid = head_valid_o;
    end

    assign read_ptr_o = read_ptr_q;

    no_alu_overwrite : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alu_entry_i.valid |-> !valid_q[alu_tag_i]);

    no_mul_overwrite : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_entry_i.valid |-> !valid_q[mul_tag_i]);

    retire_needs_head : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_i |-> head_valid_o);

endmodule : reorder_buffer

`default_nettype wire

//--- hdl/commit_stage.sv
`default_nettype none

module commit_stage
    import core_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  exu_result_t alu_result_i,
    input  exu_result_t mul_result_i,
    output rob_entry_t  alu_entry_o,
    output rob_tag_t    alu_tag_o,
    output rob_entry_t  mul_entry_o,
    output rob_tag_t    mul_tag_o
);

    // Repack a unit result into the reorder buffer layout
    function automatic rob_entry_t build_entry(input exu_result_t res);
        rob_entry_t entry;
        entry.valid     = res.valid;
        entry.exception = (res.ipacket.opcode == OP_ILLEGAL);
        entry.cause     = entry.exception ? CAUSE_ILLEGAL : CAUSE_NONE;
        entry.pc        = res.ipacket.pc;
        entry.dest      = res.ipacket.dest;
        entry.result    = res.result;
        return entry;
    endfunction

    always_ff @(posedge clk_i) begin : stage_register
        if (!rst_n_i || flush_i) begin
            alu_entry_o.valid <= 1'b0;
            mul_entry_o.valid <= 1'b0;
        end else begin
            alu_entry_o <= build_entry(alu_result_i);
            mul_entry_o <= build_entry(mul_result_i);
            alu_tag_o   <= alu_result_i.ipacket.tag;        // Write address in the ROB
            mul_tag_o   <= mul_result_i.ipacket.tag;
        end
    end

endmodule : commit_stage

`default_nettype wire

//--- execution/execution_unit.sv
`default_nettype none

module execution_unit
    import core_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          flush_i,
    input  logic          issue_valid_i,
    input  data_word_t    operand_1_i,
    input  data_word_t    operand_2_i,
    input  instr_packet_t ipacket_i,
    output exu_result_t   alu_result_o,
    output exu_result_t   mul_result_o
);

    logic        alu_issue, mul_issue;
    data_word_t  alu_value;
    logic [31:0] mul_low_low;                           // Low halves product
    logic [15:0] mul_cross;                             // Cross terms, only low half matters
    logic [15:0] cross_s1_q;
    exu_result_t alu_q;
    exu_result_t mul_s1_q, mul_s2_q, mul_s3_q;

    assign alu_issue = issue_valid_i && (ipacket_i.opcode != OP_MUL);
    assign mul_issue = issue_valid_i && (ipacket_i.opcode == OP_MUL);

    always_comb begin : alu_logic
        case (ipacket_i.opcode)
            OP_ADD:  alu_value = operand_1_i + operand_2_i;
            OP_SUB:  alu_value = operand_1_i - operand_2_i;
            OP_AND:  alu_value = operand_1_i & operand_2_i;
            OP_OR:   alu_value = operand_1_i | operand_2_i;
            OP_XOR:  alu_value = operand_1_i ^ operand_2_i;
            default: alu_value = '0;                    // Illegal ops carry a zero result
        endcase
    end

    always_ff @(posedge clk_i) begin : alu_register
        if (!rst_n_i || flush_i) begin
            alu_q.valid <= 1'b0;
        end else begin
            alu_q <= '{valid: alu_issue, ipacket: ipacket_i, result: alu_value};
        end
    end

    // Low word of a*b = al*bl + ((al*bh + ah*bl) << 16)
    assign mul_low_low = operand_1_i[15:0] * operand_2_i[15:0];
    assign mul_cross   = operand_1_i[15:0] * operand_2_i[31:16]
                       + operand_1_i[31:16] * operand_2_i[15:0];

    always_ff @(posedge clk_i) begin : mul_pipeline
        if (!rst_n_i || flush_i) begin
            mul_s1_q.valid <= 1'b0;
            mul_s2_q.valid <= 1'b0;
            mul_s3_q.valid <= 1'b0;
        end else begin
            mul_s1_q        <= '{valid: mul_issue, ipacket: ipacket_i, result: mul_low_low};
            cross_s1_q      <= mul_cross;
            mul_s2_q        <= mul_s1_q;
            mul_s2_q.result <= mul_s1_q.result + {cross_s1_q, 16'h0000};  // Partial sum
            mul_s3_q        <= mul_s2_q;
        end
    end

    assign alu_result_o = alu_q;
    assign mul_result_o = mul_s3_q;

    // Tags stay unique as long as the front end keeps fewer than ROB_DEPTH in flight
    unique_result_tags : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (alu_result_o.valid && mul_result_o.valid)
            |-> (alu_result_o.ipacket.tag != mul_result_o.ipacket.tag));

endmodule : execution_unit

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int ROB_DEPTH = 8;                       // Reorder buffer entries
    localparam int TAG_BITS  = $clog2(ROB_DEPTH);

    typedef logic [31:0]         data_word_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [TAG_BITS-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,                                         // Goes to the multiplier
        OP_ILLEGAL                                      // Raises an exception at retire
    } exu_op_t;

    typedef struct packed {
        data_word_t pc;
        reg_addr_t  dest;
        rob_tag_t   tag;                                // Issue count modulo ROB_DEPTH
        exu_op_t    opcode;
    } instr_packet_t;

    typedef struct packed {
        logic          valid;
        instr_packet_t ipacket;
        data_word_t    result;
    } exu_result_t;

    typedef struct packed {
        logic                 valid;
        logic                 exception;
        trap_pkg::trap_cause_t cause;
        data_word_t           pc;
        reg_addr_t            dest;
        data_word_t           result;
    } rob_entry_t;

endpackage : core_pkg

`default_nettype wire

//--- common/trap_pkg.sv
`default_nettype none

package trap_pkg;

    // Machine cause codes reported by the writeback stage
    typedef enum logic [4:0] {
        CAUSE_NONE    = 5'd0,                   // No exception pending
        CAUSE_ILLEGAL = 5'd2                    // Illegal instruction
    } trap_cause_t;

    typedef enum logic [1:0] {
        TRAP_IDLE,                              // Normal execution
        TRAP_FLUSH,                             // Pipeline clear and redirect
        TRAP_HANDLER                            // Front end parked in handler
    } trap_state_t;

    // Vector base, each cause owns one word
    localparam logic [31:0] HANDLER_BASE = 32'h0000_0100;

endpackage : trap_pkg

`default_nettype wire
